// File: sim.f
logic/frame_pkg.sv
logic/reply_pkg.sv
logic/frame_ram.sv
logic/frame_receiver.sv
logic/header_reader.sv
logic/reply_builder.sv
logic/frame_checksum.sv
logic/frame_transmitter.sv
logic/frame_handler.sv
test/frame_handler_properties.sv
test/frame_monitor.sv
test/tb_frame_handler.sv

// File: run.sh
#!/bin/sh
# build and run the frame handler regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_frame_handler -f sim.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx "Regression passed" sim.log; then
  echo "run ok, see sim.log"
  exit 0
fi
echo "run not ok, see sim.log"
exit 1

// File: test/tb_frame_handler.sv
`timescale 1ns/1ps

module tb_frame_handler;
  import frame_pkg::*;

  localparam int          NUM_FRAMES      = 20;
  localparam int          NO_REPLY_WINDOW = 400;
  localparam int          POP_TIMEOUT     = 100;
  localparam int          REPLY_TIMEOUT   = 4000;
  localparam logic [15:0] SEED            = 16'd11409;

  logic          i_clk;
  logic          i_rst;
  logic          i_rready;
  byte_t         i_rdata;
  logic          o_rreq;
  logic          i_wready;
  byte_t         o_wdata;
  logic          o_wvalid;
  logic          frame_valid;
  int            frame_len;
  frame_header_t frame_hdr;
  byte_t         frame_bytes [$];
  int            mon_errors;
  int            mon_pending;
  int            tb_errors;
  logic          timed_out;
  logic [15:0]   lfsr;
  logic [15:0]   stall_lfsr;

  frame_handler i_frame_handler (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_rready (i_rready),
    .i_rdata  (i_rdata),
    .o_rreq   (o_rreq),
    .i_wready (i_wready),
    .o_wdata  (o_wdata),
    .o_wvalid (o_wvalid)
  );

  frame_monitor monitor (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_rreq        (o_rreq),
    .i_wready      (i_wready),
    .i_wvalid      (o_wvalid),
    .i_wdata       (o_wdata),
    .i_frame_valid (frame_valid),
    .i_frame_len   (frame_len),
    .i_frame_hdr   (frame_hdr),
    .o_errors      (mon_errors),
    .o_pending     (mon_pending)
  );

  ////////////////////
  // random source
  ////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic byte_t type_for(input int pick);
    case (pick)
      0:       return 8'h01;
      1:       return 8'h81;
      2:       return 8'h04;
      3:       return 8'h11;
      default: return 8'h02;
    endcase
  endfunction

  ////////////////////
  // clock and sink stalls
  ////////////////////

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // about one cycle in four holds i_wready low
  initial begin
    logic b0;
    logic b1;
    i_wready   = 1'b0;
    stall_lfsr = SEED;
    forever begin
      @(posedge i_clk);
      #1;
      stall_lfsr = lfsr_step(stall_lfsr);
      b0         = stall_lfsr[0];
      stall_lfsr = lfsr_step(stall_lfsr);
      b1         = stall_lfsr[0];
      i_wready   = !(b0 && b1);
    end
  end

  ////////////////////
  // frame tasks
  ////////////////////

  task automatic make_frame(input int num);
    int pick;
    int v;
    // first five frames walk through every type once
    if (num < 5) begin
      pick = num;
    end else begin
      take_bits(3, v);
      pick = v % 5;
    end
    take_bits(6, v);
    frame_len = 7 + v % 34;
    take_bits(16, v);
    frame_hdr.src = 16'(v);
    take_bits(16, v);
    frame_hdr.dst   = 16'(v);
    frame_hdr.size  = 16'(frame_len);
    frame_hdr.dtype = type_for(pick);
    frame_bytes.delete();
    frame_bytes.push_back(frame_hdr.src[15:8]);
    frame_bytes.push_back(frame_hdr.src[7:0]);
    frame_bytes.push_back(frame_hdr.dst[15:8]);
    frame_bytes.push_back(frame_hdr.dst[7:0]);
    frame_bytes.push_back(frame_hdr.size[15:8]);
    frame_bytes.push_back(frame_hdr.size[7:0]);
    frame_bytes.push_back(frame_hdr.dtype);
    for (int i = 7; i < frame_len; i++) begin
      take_bits(8, v);
      frame_bytes.push_back(8'(v));
    end
  endtask

  task automatic send_frame(input int num);
    int   gap;
    int   waited;
    logic popped;
    for (int i = 0; i < frame_len && !timed_out; i++) begin
      take_bits(5, gap);
      repeat (gap % 21) begin
        @(posedge i_clk);
        #1;
      end
      i_rready = 1'b1;
      popped   = 1'b0;
      waited   = 0;
      while (!popped && waited < POP_TIMEOUT) begin
        @(posedge i_clk);
        #1;
        popped = o_rreq;
        waited++;
      end
      if (popped) begin
        // byte has to sit on i_rdata in the cycle after the pop
        i_rdata  = frame_bytes[i];
        i_rready = 1'b0;
      end else begin
        $display("timeout: byte %0d of frame %0d was never popped", i, num);
        tb_errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic mark_frame_end();
    frame_valid = 1'b1;
    @(posedge i_clk);
    #1;
    frame_valid = 1'b0;
  endtask

  task automatic await_reply(input int num);
    int waited;
    waited = 0;
    if (mon_pending > 0) begin
      while (mon_pending > 0 && waited < REPLY_TIMEOUT) begin
        @(posedge i_clk);
        #1;
        waited++;
      end
      if (mon_pending > 0) begin
        $display("timeout: reply to frame %0d still missing %0d bytes", num, mon_pending);
        tb_errors++;
        timed_out = 1'b1;
      end
    end else begin
      // window in which no reply may appear
      repeat (NO_REPLY_WINDOW) begin
        @(posedge i_clk);
        #1;
      end
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int total;
    int prop_errors;
    i_rst       = 1'b1;
    i_rready    = 1'b0;
    i_rdata     = 8'h00;
    frame_valid = 1'b0;
    frame_len   = 0;
    frame_hdr   = '0;
    tb_errors   = 0;
    timed_out   = 1'b0;
    lfsr        = SEED;
    repeat (8) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
      make_frame(f);
      send_frame(f);
      if (!timed_out) begin
        mark_frame_end();
        await_reply(f);
      end
    end
    prop_errors = i_frame_handler.i_properties.fail_cnt;
    total       = tb_errors + mon_errors + prop_errors;
    $display("frames %0d, total errors %0d (monitor %0d, assertions %0d, testbench %0d)",
             NUM_FRAMES, total, mon_errors, prop_errors, tb_errors);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: test/frame_monitor.sv
`timescale 1ns/1ps

module frame_monitor (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_rreq,
  input  logic                     i_wready,
  input  logic                     i_wvalid,
  input  frame_pkg::byte_t         i_wdata,
  input  logic                     i_frame_valid,
  input  int                       i_frame_len,
  input  frame_pkg::frame_header_t i_frame_hdr,
  output int                       o_errors,
  output int                       o_pending
);
  import frame_pkg::*;

  byte_t exp_q [$];
  byte_t exp_byte;
  int    pop_cnt;
  int    byte_idx;

  // zero when the frame gets no reply
  function automatic int reply_len(input byte_t dtype);
    if (dtype[4]) begin
      return 0;
    end
    if (dtype[4:0] == 5'd1) begin
      return 10;
    end
    if (dtype[4:0] == 5'd4) begin
      return 11;
    end
    return 0;
  endfunction

  // fixed bytes between the addresses and the checksum
  function automatic byte_t body_byte(input int len, input int i);
    if (len == 10) begin
      case (i)
        5:       return 8'h01;
        6:       return 8'h81;
        default: return 8'h00;
      endcase
    end
    case (i)
      5:       return 8'h02;
      6:       return 8'h92;
      7:       return 8'h01;
      8:       return 8'h20;
      default: return 8'h00;
    endcase
  endfunction

  task automatic queue_reply(input frame_header_t hdr);
    byte_t r [$];
    csum_t sum;
    int    len;
    len = reply_len(hdr.dtype);
    sum = '0;
    if (len > 0) begin
      for (int i = 0; i < TX_FRAME_LEN; i++) begin
        r.push_back(8'h00);
      end
      // reply goes back to the sender
      r[0] = hdr.dst[15:8];
      r[1] = hdr.dst[7:0];
      r[2] = hdr.src[15:8];
      r[3] = hdr.src[7:0];
      for (int i = 4; i < len - 2; i++) begin
        r[i] = body_byte(len, i);
      end
      for (int i = 0; i < len - 2; i++) begin
        sum = sum + csum_t'(r[i]);
      end
      r[len - 2] = sum[15:8];
      r[len - 1] = sum[7:0];
      for (int i = 0; i < TX_FRAME_LEN; i++) begin
        exp_q.push_back(r[i]);
      end
    end
  endtask

  always @(posedge i_clk) begin
    if (i_rst) begin
      exp_q.delete();
      pop_cnt   = 0;
      byte_idx  = 0;
      o_errors  = 0;
      o_pending = 0;
    end else begin
      if (i_rreq) begin
        pop_cnt++;
      end
      if (i_frame_valid) begin
        if (pop_cnt != i_frame_len) begin
          $display("[FAIL] %0t o_rreq pops expected %0d actual %0d", $time, i_frame_len, pop_cnt);
          o_errors++;
        end
        if (exp_q.size() != 0) begin
          $display("reply to the previous frame is missing %0d bytes", exp_q.size());
          o_errors++;
          exp_q.delete();
        end
        pop_cnt  = 0;
        byte_idx = 0;
        queue_reply(i_frame_hdr);
      end
      if (i_wvalid && !i_wready) begin
        $display("o_wvalid was raised at %0t while i_wready was low", $time);
        o_errors++;
      end
      if (i_wvalid) begin
        if (exp_q.size() == 0) begin
          $display("unexpected byte on o_wvalid at %0t with no reply due", $time);
          o_errors++;
        end else begin
          exp_byte = exp_q.pop_front();
          if (i_wdata !== exp_byte) begin
            $display("[FAIL] %0t o_wdata byte %0d expected %02h actual %02h",
                     $time, byte_idx, exp_byte, i_wdata);
            o_errors++;
          end
          byte_idx++;
        end
      end
      o_pending = exp_q.size();
    end
  end

endmodule

// File: test/frame_handler_properties.sv
`timescale 1ns/1ps

module frame_handler_properties (
  input logic i_clk,
  input logic i_rst,
  input logic i_wready,
  input logic o_wvalid,
  input logic o_rreq
);

  int fail_cnt = 0;

  // write pulse only when the sink can take it
  wvalid_needs_wready: assert property (
    @(posedge i_clk) disable iff (i_rst) o_wvalid |-> i_wready
  ) else begin
    $error("o_wvalid high while i_wready low");
    fail_cnt++;
  end

  quiet_after_reset: assert property (
    @(posedge i_clk) i_rst |=> (!o_rreq && !o_wvalid)
  ) else begin
    $error("o_rreq or o_wvalid high right after reset");
    fail_cnt++;
  end

  // pops are single cycle pulses
  rreq_single_pulse: assert property (
    @(posedge i_clk) disable iff (i_rst) o_rreq |=> !o_rreq
  ) else begin
    $error("o_rreq held high for two cycles");
    fail_cnt++;
  end

endmodule

bind frame_handler frame_handler_properties i_properties (.*);

// File: logic/frame_handler.sv
`timescale 1ns/1ps

module frame_handler (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_rready,
  input  frame_pkg::byte_t i_rdata,
  output logic             o_rreq,
  input  logic             i_wready,
  output frame_pkg::byte_t o_wdata,
  output logic             o_wvalid
);
  import frame_pkg::*;

  typedef enum logic [2:0] {
    C_IDLE, C_RECEIVE, C_PARSE, C_BUILD, C_SUM, C_SEND
  } ctrl_e;

  ctrl_e         state;
  logic          rx_start, hdr_start, bld_start, sum_start, tx_start;
  logic          rx_done, hdr_done, bld_done, sum_done, tx_done;
  logic          bld_reply;
  byte_t         reply_len;
  byte_t         ram_rdata;
  ram_req_t      rx_req, hdr_req, bld_req, sum_req, tx_req;
  frame_header_t header;

  ////////////////////
  // controller
  ////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= C_IDLE;
      rx_start  <= 1'b0;
      hdr_start <= 1'b0;
      bld_start <= 1'b0;
      sum_start <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      rx_start  <= 1'b0;
      hdr_start <= 1'b0;
      bld_start <= 1'b0;
      sum_start <= 1'b0;
      tx_start  <= 1'b0;
      case (state)
        C_IDLE: begin
          if (i_rready) begin
            rx_start <= 1'b1;
            state    <= C_RECEIVE;
          end
        end
        C_RECEIVE: begin
          if (rx_done) begin
            hdr_start <= 1'b1;
            state     <= C_PARSE;
          end
        end
        C_PARSE: begin
          if (hdr_done) begin
            bld_start <= 1'b1;
            state     <= C_BUILD;
          end
        end
        C_BUILD: begin
          if (bld_done) begin
            // no reply, go back for the next frame
            sum_start <= bld_reply;
            state     <= bld_reply ? C_SUM : C_IDLE;
          end
        end
        C_SUM: begin
          if (sum_done) begin
            tx_start <= 1'b1;
            state    <= C_SEND;
          end
        end
        C_SEND: begin
          if (tx_done) begin
            state <= C_IDLE;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  ////////////////////
  // units
  ////////////////////

  frame_ram i_frame_ram (
    .i_clk     (i_clk),
    .i_rx_req  (rx_req),
    .i_hdr_req (hdr_req),
    .i_bld_req (bld_req),
    .i_sum_req (sum_req),
    .i_tx_req  (tx_req),
    .o_rdata   (ram_rdata)
  );

  frame_receiver i_frame_receiver (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (rx_start),
    .i_rready  (i_rready),
    .i_rdata   (i_rdata),
    .o_rreq    (o_rreq),
    .o_ram_req (rx_req),
    .o_done    (rx_done)
  );

  header_reader i_header_reader (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (hdr_start),
    .i_rdata   (ram_rdata),
    .o_ram_req (hdr_req),
    .o_header  (header),
    .o_done    (hdr_done)
  );

  reply_builder i_reply_builder (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (bld_start),
    .i_header  (header),
    .o_ram_req (bld_req),
    .o_len     (reply_len),
    .o_reply   (bld_reply),
    .o_done    (bld_done)
  );

  frame_checksum i_frame_checksum (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (sum_start),
    .i_len     (reply_len),
    .i_rdata   (ram_rdata),
    .o_ram_req (sum_req),
    .o_done    (sum_done)
  );

  frame_transmitter i_frame_transmitter (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (tx_start),
    .i_len     (reply_len),
    .i_rdata   (ram_rdata),
    .i_wready  (i_wready),
    .o_ram_req (tx_req),
    .o_wdata   (o_wdata),
    .o_wvalid  (o_wvalid),
    .o_done    (tx_done)
  );

endmodule

// File: logic/frame_transmitter.sv
`timescale 1ns/1ps

module frame_transmitter (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  frame_pkg::byte_t    i_len,
  input  frame_pkg::byte_t    i_rdata,
  input  logic                i_wready,
  output frame_pkg::ram_req_t o_ram_req,
  output frame_pkg::byte_t    o_wdata,
  output logic                o_wvalid,
  output logic                o_done
);
  import frame_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_LOAD, S_SEND} state_e;

  state_e    state;
  ram_addr_t idx;
  byte_t     wdata_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= S_ADDR;
          end
        end
        S_ADDR: state <= S_LOAD;
        S_LOAD: state <= S_SEND;
        S_SEND: begin
          // hold the byte until the port takes it
          if (i_wready) begin
            if (idx == ram_addr_t'(TX_FRAME_LEN - 1)) begin
              o_done <= 1'b1;
              state  <= S_IDLE;
            end else begin
              idx   <= idx + 8'd1;
              state <= S_ADDR;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // zero padding past the reply
  always_ff @(posedge i_clk) begin
    if (state == S_LOAD) begin
      wdata_q <= (idx < i_len) ? i_rdata : '0;
    end
  end

  always_comb begin
    o_ram_req = '0;
    if (state == S_ADDR || state == S_LOAD) begin
      o_ram_req.addr = idx;
    end
  end

  assign o_wvalid = (state == S_SEND) && i_wready;
  assign o_wdata  = wdata_q;

endmodule

// File: logic/frame_checksum.sv
`timescale 1ns/1ps

module frame_checksum (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  frame_pkg::byte_t    i_len,
  input  frame_pkg::byte_t    i_rdata,
  output frame_pkg::ram_req_t o_ram_req,
  output logic                o_done
);
  import frame_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_ADDR, S_LOAD, S_WR_HI, S_WR_LO} state_e;

  state_e    state;
  ram_addr_t idx;
  csum_t     sum_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= S_ADDR;
          end
        end
        S_ADDR: state <= S_LOAD;
        S_LOAD: begin
          // stop short of the two checksum bytes
          if (idx == i_len - 8'd3) begin
            state <= S_WR_HI;
          end else begin
            idx   <= idx + 8'd1;
            state <= S_ADDR;
          end
        end
        S_WR_HI: state <= S_WR_LO;
        S_WR_LO: begin
          o_done <= 1'b1;
          state  <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && i_start) begin
      sum_q <= '0;
    end else if (state == S_LOAD) begin
      sum_q <= sum_q + csum_t'(i_rdata);
    end
  end

  always_comb begin
    o_ram_req = '0;
    case (state)
      S_ADDR, S_LOAD: o_ram_req.addr = idx;
      S_WR_HI: begin
        o_ram_req.we    = 1'b1;
        o_ram_req.addr  = i_len - 8'd2;
        o_ram_req.wdata = sum_q[15:8];
      end
      S_WR_LO: begin
        o_ram_req.we    = 1'b1;
        o_ram_req.addr  = i_len - 8'd1;
        o_ram_req.wdata = sum_q[7:0];
      end
      default: o_ram_req = '0;
    endcase
  end

endmodule

// File: logic/reply_builder.sv
`timescale 1ns/1ps

module reply_builder (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_start,
  input  frame_pkg::frame_header_t i_header,
  output frame_pkg::ram_req_t      o_ram_req,
  output frame_pkg::byte_t         o_len,
  output logic                     o_reply,
  output logic                     o_done
);
  import frame_pkg::*;
  import reply_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_TSET, S_TWR, S_SWAP} state_e;

  state_e     state;
  command_e   cmd;
  logic       is_grant;
  logic [3:0] idx;
  byte_t      len_q;
  byte_t      tpl_byte;
  byte_t      swap_byte;

  assign cmd = command_e'(i_header.dtype[4:0]);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= S_IDLE;
      idx      <= '0;
      is_grant <= 1'b0;
      len_q    <= '0;
      o_reply  <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx     <= '0;
            o_reply <= 1'b0;
            // acks and unknown commands are dropped
            if (i_header.dtype[ACK_BIT] || (cmd != CMD_PING && cmd != CMD_GRANT)) begin
              o_done <= 1'b1;
            end else begin
              is_grant <= (cmd == CMD_GRANT);
              len_q    <= (cmd == CMD_GRANT) ? byte_t'(GRANT_LEN) : byte_t'(PING_LEN);
              state    <= S_TSET;
            end
          end
        end
        S_TSET: state <= S_TWR;
        S_TWR: begin
          if (byte_t'(idx) == len_q - 8'd1) begin
            idx   <= '0;
            state <= S_SWAP;
          end else begin
            idx   <= idx + 4'd1;
            state <= S_TSET;
          end
        end
        S_SWAP: begin
          if (idx == 4'd3) begin
            o_reply <= 1'b1;
            o_done  <= 1'b1;
            state   <= S_IDLE;
          end else begin
            idx <= idx + 4'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_comb begin
    tpl_byte = is_grant ? GRANT_TEMPLATE[idx] : PING_TEMPLATE[idx];
    // reply goes back to the sender: dst first, then src
    case (idx[1:0])
      2'd0:    swap_byte = i_header.dst[15:8];
      2'd1:    swap_byte = i_header.dst[7:0];
      2'd2:    swap_byte = i_header.src[15:8];
      default: swap_byte = i_header.src[7:0];
    endcase
  end

  always_comb begin
    o_ram_req = '0;
    case (state)
      S_TWR: begin
        o_ram_req.we    = 1'b1;
        o_ram_req.addr  = ram_addr_t'(idx);
        o_ram_req.wdata = tpl_byte;
      end
      S_SWAP: begin
        o_ram_req.we    = 1'b1;
        o_ram_req.addr  = ram_addr_t'(idx);
        o_ram_req.wdata = swap_byte;
      end
      default: o_ram_req = '0;
    endcase
  end

  assign o_len = len_q;

endmodule

// File: logic/header_reader.sv
`timescale 1ns/1ps

module header_reader (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_start,
  input  frame_pkg::byte_t         i_rdata,
  output frame_pkg::ram_req_t      o_ram_req,
  output frame_pkg::frame_header_t o_header,
  output logic                     o_done
);
  import frame_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_LOAD} state_e;

  state_e        state;
  logic [2:0]    idx;
  frame_header_t hdr_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            idx   <= '0;
            state <= S_ADDR;
          end
        end
        S_ADDR: state <= S_LOAD;
        S_LOAD: begin
          if (idx == 3'(HEADER_LEN - 1)) begin
            o_done <= 1'b1;
            state  <= S_IDLE;
          end else begin
            idx   <= idx + 3'd1;
            state <= S_ADDR;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // byte 0 lands in the top bits of the struct
  always_ff @(posedge i_clk) begin
    if (state == S_LOAD) begin
      hdr_q[8 * (HEADER_LEN - 1 - int'(idx)) +: 8] <= i_rdata;
    end
  end

  always_comb begin
    o_ram_req = '0;
    if (state != S_IDLE) begin
      o_ram_req.addr = ram_addr_t'(idx);
    end
  end

  assign o_header = hdr_q;

endmodule

// File: logic/frame_receiver.sv
`timescale 1ns/1ps

module frame_receiver (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_start,
  input  logic                i_rready,
  input  frame_pkg::byte_t    i_rdata,
  output logic                o_rreq,
  output frame_pkg::ram_req_t o_ram_req,
  output logic                o_done
);
  import frame_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_POP, S_WRITE} state_e;

  state_e     state;
  ram_addr_t  wr_addr;
  logic [5:0] idle_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= S_IDLE;
      wr_addr  <= '0;
      idle_cnt <= '0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (i_start) begin
            wr_addr  <= '0;
            idle_cnt <= '0;
            state    <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (i_rready) begin
            idle_cnt <= '0;
            state    <= S_POP;
          end else if (idle_cnt == 6'(RX_IDLE_LIMIT - 1)) begin
            // line quiet long enough, frame is over
            o_done <= 1'b1;
            state  <= S_IDLE;
          end else begin
            idle_cnt <= idle_cnt + 6'd1;
          end
        end
        S_POP:   state <= S_WRITE;
        S_WRITE: begin
          wr_addr <= wr_addr + 8'd1;
          state   <= S_WAIT;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // byte popped here shows up on i_rdata one cycle later
  assign o_rreq = (state == S_POP);

  always_comb begin
    o_ram_req = '0;
    if (state == S_WRITE) begin
      o_ram_req.we    = 1'b1;
      o_ram_req.addr  = wr_addr;
      o_ram_req.wdata = i_rdata;
    end
  end

endmodule

// File: logic/frame_ram.sv
`timescale 1ns/1ps

module frame_ram (
  input  logic                i_clk,
  input  frame_pkg::ram_req_t i_rx_req,
  input  frame_pkg::ram_req_t i_hdr_req,
  input  frame_pkg::ram_req_t i_bld_req,
  input  frame_pkg::ram_req_t i_sum_req,
  input  frame_pkg::ram_req_t i_tx_req,
  output frame_pkg::byte_t    o_rdata
);
  import frame_pkg::*;

  ram_req_t req;
  byte_t    mem [256];

  // idle units drive zero, so the OR acts as the mux
  assign req = i_rx_req | i_hdr_req | i_bld_req | i_sum_req | i_tx_req;

  always_ff @(posedge i_clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
    o_rdata <= mem[req.addr];
  end

endmodule

// File: logic/reply_pkg.sv
package reply_pkg;

  typedef enum logic [4:0] {
    CMD_PING  = 5'd1,
    CMD_GRANT = 5'd4
  } command_e;

  localparam int PING_LEN  = 10;
  localparam int GRANT_LEN = 11;

  // bytes 0..3 get overwritten by the swapped addresses
  localparam frame_pkg::byte_t PING_TEMPLATE [PING_LEN] = '{
    8'hff, 8'hff, 8'h00, 8'h00, 8'h00,
    8'h01, 8'h81, 8'h00, 8'h00, 8'h00
  };

  // last two bytes of each template hold the checksum
  localparam frame_pkg::byte_t GRANT_TEMPLATE [GRANT_LEN] = '{
    8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h02,
    8'h92, 8'h01, 8'h20, 8'h00, 8'h00
  };

endpackage

// File: logic/frame_pkg.sv
package frame_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  ram_addr_t;
  typedef logic [15:0] node_addr_t;
  typedef logic [15:0] csum_t;

  // field order matches header bytes 0 to 6, high byte first
  typedef struct packed {
    node_addr_t  src;
    node_addr_t  dst;
    logic [15:0] size;
    byte_t       dtype;
  } frame_header_t;

  typedef struct packed {
    logic      we;
    ram_addr_t addr;
    byte_t     wdata;
  } ram_req_t;

  localparam int HEADER_LEN    = 7;
  localparam int RX_IDLE_LIMIT = 63;
  localparam int TX_FRAME_LEN  = 50;
  localparam int ACK_BIT       = 4;

endpackage
